/* vlog.f */
src/udp_tx_pkg.sv
src/sample_trigger.sv
src/udp_frame_tx.sv
src/status_display.sv
src/udp_sample_tx.sv
verification/udp_tx_sva.sv
verification/udp_tx_checker.sv
verification/tb_udp_sample_tx.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the UDP sample sender testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_udp_sample_tx; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_udp_sample_tx); then
    echo "$sim_out"
    echo "simulation exited with an error"
    exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* verification/tb_udp_sample_tx.sv */
// Testbench top for the UDP sample sender with clock, reset, stimulus, random ready and run limit
`timescale 1ns/100ps

module tb_udp_sample_tx;

    // Six tests of up to about 150 cycles each, doubled for margin
    localparam int test_count      = 6;
    localparam int cycles_per_test = 150;
    localparam int max_cycles      = 2 * test_count * cycles_per_test + 200;

    logic                 clk;
    logic                 rst;
    logic                 enable;
    logic                 adc_valid;
    udp_tx_pkg::sample_t  sample;
    udp_tx_pkg::tx_cfg_t  cfg;
    logic                 tx_ready;
    logic                 tx_valid;
    udp_tx_pkg::tx_beat_t tx_beat;
    logic [31:0]          tx_dest_ip;
    logic [7:0]           ledg;
    logic [7:0][6:0]      hex;
    logic                 test_done;
    logic                 rand_ready;
    int                   test_id;
    int                   err_count;
    int                   tests_run;
    int                   tests_failed;
    int                   frames_done;
    int                   seed;
    int                   cycles;

    udp_sample_tx u_udp_sample_tx (.*);

    udp_tx_checker u_udp_tx_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", max_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // Inputs change 1 ns after the edge, ready too
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            tx_ready = rand_ready ? 1'($random(seed)) : 1'b1;
        end
    endtask

    task automatic end_test();
        test_done = 1'b1;
        step(1);
        test_done = 1'b0;
    endtask

    // Holds adc_valid high for hold cycles, then waits for the frame to finish
    task automatic send_frame(input udp_tx_pkg::sample_t s, input udp_tx_pkg::tx_cfg_t c,
                              input int hold);
        int target;
        target    = frames_done + 1;
        sample    = s;
        cfg       = c;
        adc_valid = 1'b1;
        step(hold);
        adc_valid = 1'b0;
        while (frames_done < target) begin
            step(1);
        end
    endtask

    initial begin
        udp_tx_pkg::sample_t s;
        udp_tx_pkg::tx_cfg_t c;
        seed       = 1;
        rand_ready = 1'b0;
        rst        = 1'b1;
        enable     = 1'b0;
        adc_valid  = 1'b0;
        sample     = '0;
        cfg        = '0;
        tx_ready   = 1'b1;
        test_id    = 0;
        test_done  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        test_id = 1;
        step(2);
        end_test();

        test_id = 2;
        enable  = 1'b1;
        send_frame({16'h12a5, 16'h0340, 16'hbeef}, {32'hc0a8_0102, 16'd5000}, 1);
        end_test();

        // Edges with the switch off
        test_id = 3;
        enable  = 1'b0;
        repeat (3) begin
            adc_valid = 1'b1;
            step(2);
            adc_valid = 1'b0;
            step(3);
        end
        step(50);
        enable = 1'b1;
        end_test();

        test_id = 4;
        send_frame({16'h7f01, 16'h0002, 16'h0a0b}, {32'h0a00_0001, 16'd80}, 100);
        end_test();

        test_id    = 5;
        rand_ready = 1'b1;
        repeat (3) begin
            s.n         = 16'($random(seed));
            s.m         = 16'($random(seed));
            s.adc_data  = 16'($random(seed));
            c.dest_ip   = 32'($random(seed));
            c.dest_port = 16'($random(seed));
            send_frame(s, c, 1);
            step(2 + ($random(seed) & 7));
        end
        end_test();

        test_id = 6;
        send_frame({16'hc35a, 16'h1111, 16'h2222}, {32'h89ab_cdef, 16'd4321}, 1);
        rand_ready = 1'b0;
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verification/udp_tx_checker.sv */
// Scoreboard for the UDP sample sender that predicts each frame and checks stream and display
`timescale 1ns/100ps

module udp_tx_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enable,
    input  logic                 adc_valid,
    input  udp_tx_pkg::sample_t  sample,
    input  udp_tx_pkg::tx_cfg_t  cfg,
    input  logic                 tx_valid,
    input  logic                 tx_ready,
    input  udp_tx_pkg::tx_beat_t tx_beat,
    input  logic [31:0]          tx_dest_ip,
    input  logic [7:0]           ledg,
    input  logic [7:0][6:0]      hex,
    input  int                   test_id,
    input  logic                 test_done,
    output int                   err_count,
    output int                   tests_run,
    output int                   tests_failed,
    output int                   frames_done
);

    // Plain gfedcba hex font before the board inverts it
    localparam logic [6:0] seg_font [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
        7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

    udp_tx_pkg::sample_t samp_q [$];
    udp_tx_pkg::tx_cfg_t cfg_q [$];
    logic [13:0][7:0]    exp_frame;
    logic [31:0]         exp_ip;
    logic [7:0]          exp_ledg;
    logic [3:0]          beat_idx;
    logic                adc_prev;
    logic                disp_pending;
    int                  err_mark;

    function automatic string test_name(input int id);
        case (id)
            1: return "reset_values";
            2: return "single_frame";
            3: return "enable_low";
            4: return "held_valid";
            5: return "random_ready";
            6: return "display";
            default: return "setup";
        endcase
    endfunction

    // Index i holds datagram byte i+1 with every 16-bit field MSB first
    function automatic logic [13:0][7:0] expected_frame(input udp_tx_pkg::sample_t s,
                                                         input udp_tx_pkg::tx_cfg_t c);
        logic [6:0][15:0] words;
        logic [13:0][7:0] frame;
        words = {s.adc_data, s.m, s.n, 16'd0, 16'd14, c.dest_port, 16'd1234};
        for (int i = 0; i < 7; i++) begin
            frame[2*i]   = words[i][15:8];
            frame[2*i+1] = words[i][7:0];
        end
        return frame;
    endfunction

    task automatic compare_field(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s expected %h actual %h", test_name(test_id), what, expected,
                     actual);
            err_count++;
        end
    endtask

    task automatic check_display(input logic [7:0] led_exp, input logic [31:0] ip);
        logic [6:0] digit;
        compare_field("ledg", 32'(led_exp), 32'(ledg));
        for (int i = 0; i < 8; i++) begin
            digit = ~seg_font[ip[4*i +: 4]];
            compare_field($sformatf("hex digit %0d", i), 32'(digit), 32'(hex[i]));
        end
    endtask

    initial begin
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        frames_done  = 0;
        err_mark     = 0;
        beat_idx     = '0;
        adc_prev     = 1'b0;
        disp_pending = 1'b0;
    end

    always @(posedge clk) begin
        // Display settles one clock after the last beat
        if (disp_pending) begin
            check_display(exp_ledg, exp_ip);
            disp_pending = 1'b0;
            frames_done++;
        end
        if (!rst && enable && adc_valid && !adc_prev) begin
            samp_q.push_back(sample);
            cfg_q.push_back(cfg);
        end
        adc_prev = rst ? 1'b0 : adc_valid;
        if (tx_valid && tx_ready) begin
            if (samp_q.size() == 0) begin
                $display("%s: a stream beat came out with no sample pending", test_name(test_id));
                err_count++;
            end else begin
                if (beat_idx == 4'd0) begin
                    exp_frame = expected_frame(samp_q[0], cfg_q[0]);
                end
                compare_field($sformatf("byte %0d data", beat_idx + 1),
                              32'(exp_frame[beat_idx]), 32'(tx_beat.data));
                compare_field($sformatf("byte %0d last", beat_idx + 1),
                              32'(beat_idx == 4'd13), 32'(tx_beat.last));
                compare_field("tx_dest_ip", cfg_q[0].dest_ip, tx_dest_ip);
                if (beat_idx == 4'd13) begin
                    exp_ledg = samp_q[0].n[15:8];
                    exp_ip   = cfg_q[0].dest_ip;
                    void'(samp_q.pop_front());
                    void'(cfg_q.pop_front());
                    beat_idx     = '0;
                    disp_pending = 1'b1;
                end else begin
                    beat_idx++;
                end
            end
        end
        if (test_done) begin
            if (test_id == 1) begin
                compare_field("tx_valid", 32'(0), 32'(tx_valid));
                check_display(8'h00, 32'h0);
            end
            tests_run++;
            if (err_count == err_mark) begin
                $display("test %0d %s: ok", test_id, test_name(test_id));
            end else begin
                $display("test %0d %s: failed with %0d errors", test_id, test_name(test_id),
                         err_count - err_mark);
                tests_failed++;
            end
            err_mark = err_count;
        end
    end

endmodule

/* verification/udp_tx_sva.sv */
// Handshake assertions for the framer, bound into every udp_frame_tx instance
`timescale 1ns/100ps

module udp_tx_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 req,
    input logic                 ack,
    input logic                 tx_valid,
    input logic                 tx_ready,
    input udp_tx_pkg::tx_beat_t tx_beat
);

    // A stalled beat holds until the sink takes it
    beat_held: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
        else $error("tx beat changed or dropped while stalled");

    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
        else $error("ack rose without a pending req");

    // Four-phase order, req is withdrawn only once acked
    req_after_ack: assert property (@(posedge clk) disable iff (rst) $fell(req) |-> ack)
        else $error("req fell before ack was seen");

endmodule

bind udp_frame_tx udp_tx_sva u_udp_tx_sva (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .ack      (ack),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_beat  (tx_beat)
);

/* src/udp_sample_tx.sv */
// Top of the UDP sample sender, chaining trigger and framer with a status tap on the stream
`timescale 1ns/100ps

module udp_sample_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enable,
    input  logic                 adc_valid,
    input  udp_tx_pkg::sample_t  sample,
    input  udp_tx_pkg::tx_cfg_t  cfg,
    input  logic                 tx_ready,
    output logic                 tx_valid,
    output udp_tx_pkg::tx_beat_t tx_beat,
    output logic [31:0]          tx_dest_ip,
    output logic [7:0]           ledg,
    output logic [7:0][6:0]      hex
);

    logic                req;
    logic                ack;
    udp_tx_pkg::sample_t req_sample;

    sample_trigger u_sample_trigger (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .adc_valid  (adc_valid),
        .sample     (sample),
        .req        (req),
        .req_sample (req_sample),
        .ack        (ack)
    );

    udp_frame_tx u_udp_frame_tx (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_sample (req_sample),
        .ack        (ack),
        .cfg        (cfg),
        .tx_valid   (tx_valid),
        .tx_beat    (tx_beat),
        .tx_ready   (tx_ready),
        .tx_dest_ip (tx_dest_ip)
    );

    // Watches accepted beats only
    status_display u_status_display (
        .clk        (clk),
        .rst        (rst),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_beat    (tx_beat),
        .tx_dest_ip (tx_dest_ip),
        .ledg       (ledg),
        .hex        (hex)
    );

endmodule

/* src/status_display.sv */
// Taps the outgoing stream to show the first payload byte on LEDs and the dest IP on hex digits
`timescale 1ns/100ps

module status_display (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_valid,
    input  logic                 tx_ready,
    input  udp_tx_pkg::tx_beat_t tx_beat,
    input  logic [31:0]          tx_dest_ip,
    output logic [7:0]           ledg,
    output logic [7:0][6:0]      hex
);

    udp_tx_pkg::byte_index_t beat_cnt;
    logic [31:0]             ip_q;
    logic                    beat_done;

    // Hex font, segment a in bit 0, driven active low
    function automatic logic [6:0] seg_decode(input logic [3:0] nibble);
        logic [6:0] seg;
        case (nibble)
            4'h0: seg = 7'h3f;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5b;
            4'h3: seg = 7'h4f;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6d;
            4'h6: seg = 7'h7d;
            4'h7: seg = 7'h07;
            4'h8: seg = 7'h7f;
            4'h9: seg = 7'h6f;
            4'ha: seg = 7'h77;
            4'hb: seg = 7'h7c;
            4'hc: seg = 7'h39;
            4'hd: seg = 7'h5e;
            4'he: seg = 7'h79;
            default: seg = 7'h71;
        endcase
        return ~seg;
    endfunction

    assign beat_done = tx_valid && tx_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt <= '0;
            ip_q     <= '0;
            ledg     <= '0;
        end else if (beat_done) begin
            beat_cnt <= tx_beat.last ? '0 : beat_cnt + 1'b1;
            if (beat_cnt == '0) begin
                ip_q <= tx_dest_ip;
            end
            // First payload byte follows the 8-byte header
            if (beat_cnt == udp_tx_pkg::byte_index_t'(udp_tx_pkg::udp_hdr_bytes)) begin
                ledg <= tx_beat.data;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            hex[i] = seg_decode(ip_q[4*i +: 4]);
        end
    end

endmodule

/* src/udp_frame_tx.sv */
// Turns one accepted sample into a 14-byte UDP datagram on a valid/ready byte stream
`timescale 1ns/100ps

module udp_frame_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  udp_tx_pkg::sample_t  req_sample,
    output logic                 ack,
    input  udp_tx_pkg::tx_cfg_t  cfg,
    output logic                 tx_valid,
    output udp_tx_pkg::tx_beat_t tx_beat,
    input  logic                 tx_ready,
    output logic [31:0]          tx_dest_ip
);

    udp_tx_pkg::frame_state_e state;
    udp_tx_pkg::byte_index_t  byte_idx;
    udp_tx_pkg::sample_t      sample_q;
    udp_tx_pkg::tx_cfg_t      cfg_q;

    logic [8*udp_tx_pkg::udp_length-1:0] frame_bytes;
    logic start;
    logic beat_done;
    logic last_beat;

    // New request is only taken in idle with the previous handshake closed
    assign start     = (state == udp_tx_pkg::idle) && req && !ack;
    assign beat_done = tx_valid && tx_ready;
    assign last_beat = byte_idx == udp_tx_pkg::byte_index_t'(udp_tx_pkg::udp_length - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= udp_tx_pkg::idle;
            byte_idx <= '0;
            tx_valid <= 1'b0;
        end else begin
            case (state)
                udp_tx_pkg::idle: begin
                    if (start) begin
                        byte_idx <= '0;
                        tx_valid <= 1'b1;
                        state    <= udp_tx_pkg::send;
                    end
                end
                udp_tx_pkg::send: begin
                    if (beat_done) begin
                        if (last_beat) begin
                            tx_valid <= 1'b0;
                            state    <= udp_tx_pkg::done_wait;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                udp_tx_pkg::done_wait: begin
                    // A req that is still up with ack high belongs to this frame
                    if (!(req && ack)) begin
                        state <= udp_tx_pkg::idle;
                    end
                end
                default: begin
                    state    <= udp_tx_pkg::idle;
                    tx_valid <= 1'b0;
                end
            endcase
        end
    end

    // Acknowledging side of the four-phase handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else if (start) begin
            ack <= 1'b1;
        end else if (ack && !req) begin
            ack <= 1'b0;
        end
    end

    // Frame contents, held for the whole frame
    always_ff @(posedge clk) begin
        if (start) begin
            sample_q <= req_sample;
            cfg_q    <= cfg;
        end
    end

    // Header then payload, MSB first
    assign frame_bytes = {udp_tx_pkg::udp_src_port, cfg_q.dest_port,
                          udp_tx_pkg::udp_length, udp_tx_pkg::udp_checksum,
                          sample_q.n, sample_q.m, sample_q.adc_data};

    always_comb begin
        tx_beat.data = frame_bytes[8*(int'(udp_tx_pkg::udp_length) - 1 - int'(byte_idx)) +: 8];
        tx_beat.last = last_beat;
    end

    assign tx_dest_ip = cfg_q.dest_ip;

endmodule

/* src/sample_trigger.sv */
// Captures an ADC sample on an enabled rising edge of adc_valid and offers it over req/ack
`timescale 1ns/100ps

module sample_trigger (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enable,
    input  logic                 adc_valid,
    input  udp_tx_pkg::sample_t  sample,
    output logic                 req,
    output udp_tx_pkg::sample_t  req_sample,
    input  logic                 ack
);

    logic adc_valid_d;
    logic rise;
    logic take;

    // Previous adc_valid for edge detection
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            adc_valid_d <= 1'b0;
        end else begin
            adc_valid_d <= adc_valid;
        end
    end

    assign rise = adc_valid & ~adc_valid_d & enable;

    // Edges during an open handshake are dropped
    assign take = rise & ~req & ~ack;

    // Requesting side of the four-phase handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req <= 1'b0;
        end else if (take) begin
            req <= 1'b1;
        end else if (req && ack) begin
            req <= 1'b0;
        end
    end

    // Sample held stable while req is up
    always_ff @(posedge clk) begin
        if (take) begin
            req_sample <= sample;
        end
    end

endmodule

/* src/udp_tx_pkg.sv */
// Shared frame constants, FSM state type and packed structs for the UDP sample sender
package udp_tx_pkg;

    // UDP header fields that do not change at run time
    localparam logic [15:0] udp_src_port = 16'd1234;
    localparam logic [15:0] udp_checksum = 16'd0;

    localparam int udp_hdr_bytes = 8;
    localparam int payload_bytes = 6;

    // Length field value, also the beat count of one frame
    localparam logic [15:0] udp_length = 16'(udp_hdr_bytes + payload_bytes);

    // One captured ADC sample with its configuration counts
    typedef struct packed {
        logic [15:0] n;
        logic [15:0] m;
        logic [15:0] adc_data;
    } sample_t;

    // Run-time destination of the datagram
    typedef struct packed {
        logic [31:0] dest_ip;
        logic [15:0] dest_port;
    } tx_cfg_t;

    // One byte of the outgoing stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } tx_beat_t;

    // Framer FSM
    typedef enum logic [1:0] {
        idle,
        send,
        done_wait
    } frame_state_e;

    // Position of the current beat in the frame, 0 to 13
    typedef logic [3:0] byte_index_t;

endpackage
